// ==== Bender.yml ====
package:
  name: flash_cart

sources:
  - files:
      - hw/flash_pkg.sv
      - hw/mem_if.sv
      - hw/flash_cmd_decoder.sv
      - hw/flash_read_port.sv
      - hw/flash_prog_engine.sv
      - hw/flash_erase_engine.sv
      - hw/mem_arbiter.sv
      - hw/flash_top.sv
  - target: test
    files:
      - testbench/flash_assert.sv
      - testbench/flash_tb.sv

// ==== build.f ====
hw/flash_pkg.sv
hw/mem_if.sv
hw/flash_cmd_decoder.sv
hw/flash_read_port.sv
hw/flash_prog_engine.sv
hw/flash_erase_engine.sv
hw/mem_arbiter.sv
hw/flash_top.sv
testbench/flash_assert.sv
testbench/flash_tb.sv

// ==== hw/flash_cmd_decoder.sv ====
`default_nettype none

module flash_cmd_decoder (
    input  logic                   rst,
    input  logic                   clk,
    input  flash_pkg::dev_type_t   dev_type,
    input  flash_pkg::word_addr_t  cpu_addr,
    input  logic                   cpu_cs,
    input  logic [1:0]             cpu_we,
    input  flash_pkg::data_t       cpu_dout,
    input  logic                   busy,
    output logic                   id_mode,
    output logic                   read_mode,
    output flash_pkg::word_addr_t  eff_addr,
    output logic                   prog_start,
    output flash_pkg::word_addr_t  prog_addr,
    output flash_pkg::data_t       prog_data,
    output logic [1:0]             prog_dsn,
    output logic                   erase_start,
    output flash_pkg::word_addr_t  erase_base,
    output flash_pkg::block_size_t erase_size
);
    flash_pkg::flash_state_t st;
    flash_pkg::word_addr_t   ba_addr;
    flash_pkg::block_size_t  ba_size;
    logic [7:0]              cmd;
    logic                    boot_blk;
    logic                    cswe;
    logic                    cswe_l;
    logic                    act;
    logic                    at_5555;
    logic                    at_2aaa;
    logic                    id_read;

    assign cmd       = cpu_dout[7:0];
    assign cswe      = cpu_cs && cpu_we != 2'b00;
    assign act       = cswe && !cswe_l && !busy; // write edge, dropped while busy
    assign at_5555   = cpu_addr[15:1] == flash_pkg::ADDR_5555;
    assign at_2aaa   = cpu_addr[15:1] == flash_pkg::ADDR_2AAA;
    assign id_mode   = st == flash_pkg::ID_MODE;
    assign read_mode = st == flash_pkg::READ;

    // missing address lines read as zero
    always_comb begin
        eff_addr = cpu_addr;
        case (dev_type)
            flash_pkg::DEV_AB: eff_addr[20:19] = 2'b00;
            flash_pkg::DEV_2C: eff_addr[20]    = 1'b0;
            default: ;
        endcase
    end

    // top 64 kB of the device is split into boot blocks
    always_comb begin
        case (dev_type)
            flash_pkg::DEV_AB: boot_blk = &eff_addr[18:16];
            flash_pkg::DEV_2C: boot_blk = &eff_addr[19:16];
            flash_pkg::DEV_2F: boot_blk = &eff_addr[20:16];
            default:           boot_blk = 1'b0;
        endcase
        ba_addr = {eff_addr[20:13], 12'd0};
        ba_size = flash_pkg::BA_64K;
        if (!boot_blk) begin
            ba_addr[15:13] = 3'b000;
        end else begin
            casez (eff_addr[15:13])
                3'b0??: begin   // lower half
                    ba_addr[14:13] = 2'b00;
                    ba_size        = flash_pkg::BA_32K;
                end
                3'b10?: ba_size = flash_pkg::BA_8K; // two 8K blocks
                default: begin  // last quarter
                    ba_addr[13] = 1'b0;
                    ba_size     = flash_pkg::BA_16K;
                end
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st          <= flash_pkg::READ;
            cswe_l      <= 1'b0;
            prog_start  <= 1'b0;
            erase_start <= 1'b0;
            id_read     <= 1'b0;
        end else begin
            cswe_l      <= cswe;
            prog_start  <= 1'b0;
            erase_start <= 1'b0;
            id_read     <= id_mode && (id_read || (cpu_cs && cpu_we == 2'b00));
            if (act) begin
                st <= flash_pkg::READ; // any unexpected byte
                case (st)
                    flash_pkg::READ, flash_pkg::SETUP: begin
                        if (at_5555 && cmd == flash_pkg::CMD_UNLOCK1)
                            st <= st == flash_pkg::READ ? flash_pkg::UNLOCK1 : flash_pkg::SETUP1;
                    end
                    flash_pkg::UNLOCK1, flash_pkg::SETUP1: begin
                        if (at_2aaa && cmd == flash_pkg::CMD_UNLOCK2)
                            st <= st == flash_pkg::UNLOCK1 ? flash_pkg::UNLOCK2 : flash_pkg::SETUP2;
                    end
                    flash_pkg::UNLOCK2: begin
                        if (at_5555) begin
                            case (cmd)
                                flash_pkg::CMD_PROG:  st <= flash_pkg::AUTOPROG;
                                flash_pkg::CMD_SETUP: st <= flash_pkg::SETUP;
                                flash_pkg::CMD_ID:    st <= flash_pkg::ID_MODE;
                                flash_pkg::CMD_RESET,
                                flash_pkg::CMD_PROTECT: st <= flash_pkg::READ; // no protection
                                default: ;
                            endcase
                        end
                    end
                    flash_pkg::SETUP2: erase_start <= cmd == flash_pkg::CMD_ERASE;
                    flash_pkg::AUTOPROG: prog_start <= 1'b1;
                    default: ;
                endcase
            end else if (id_mode && id_read && !cpu_cs) begin
                st <= flash_pkg::READ; // id read done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act && st == flash_pkg::AUTOPROG) begin
            prog_addr <= eff_addr;
            prog_data <= cpu_dout;
            prog_dsn  <= ~cpu_we;
        end
        if (act && st == flash_pkg::SETUP2) begin
            erase_base <= ba_addr;   // block picked by the 30 write
            erase_size <= ba_size;
        end
    end

endmodule

`default_nettype wire

// ==== hw/flash_erase_engine.sv ====
`default_nettype none

module flash_erase_engine (
    input  logic                   rst,
    input  logic                   clk,
    input  logic                   erase_start,
    input  flash_pkg::word_addr_t  erase_base,
    input  flash_pkg::block_size_t erase_size,
    output logic                   busy,
    mem_if.requester               bus
);
    flash_pkg::block_size_t size;
    logic                   last;

    assign bus.we    = 1'b1;
    assign bus.dsn   = 2'b00;
    assign bus.wdata = 16'hFFFF;

    // every in-block address bit at one
    assign last = &{bus.addr[15:13] | ~size, bus.addr[12:1]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            bus.cs <= 1'b0;
        end else if (erase_start) begin
            busy   <= 1'b1;
            bus.cs <= 1'b1;
        end else if (busy) begin
            if (bus.cs && bus.ok) begin
                bus.cs <= 1'b0;
                busy   <= !last;
            end else if (!bus.cs) begin
                bus.cs <= 1'b1; // next word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (erase_start) begin
            bus.addr <= erase_base;
            size     <= erase_size;
        end else if (bus.cs && bus.ok) begin
            bus.addr[15:1] <= bus.addr[15:1] + 15'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

    typedef logic [20:1] word_addr_t;  // cpu word address
    typedef logic [15:0] data_t;
    typedef logic [2:0]  dev_type_t;
    typedef logic [2:0]  block_size_t; // bit 2..0 map to address 15..13

    // device selector values
    localparam dev_type_t DEV_2F = 3'd0; // 2 or 4 MB
    localparam dev_type_t DEV_2C = 3'd1; // 1 MB
    localparam dev_type_t DEV_AB = 3'd2; // 512 kB or smaller

    localparam logic [7:0] MFR_ID = 8'h98;

    // command bytes, low data byte only
    localparam logic [7:0] CMD_UNLOCK1 = 8'hAA;
    localparam logic [7:0] CMD_UNLOCK2 = 8'h55;
    localparam logic [7:0] CMD_SETUP   = 8'h80;
    localparam logic [7:0] CMD_ID      = 8'h90;
    localparam logic [7:0] CMD_PROG    = 8'hA0;
    localparam logic [7:0] CMD_ERASE   = 8'h30;
    localparam logic [7:0] CMD_RESET   = 8'hF0;
    localparam logic [7:0] CMD_PROTECT = 8'h9A;

    // unlock addresses as seen on cpu_addr[15:1]
    localparam logic [14:0] ADDR_5555 = 15'h2AAA;
    localparam logic [14:0] ADDR_2AAA = 15'h1555;

    // a set bit means that address bit walks inside the block
    localparam block_size_t BA_64K = 3'b111;
    localparam block_size_t BA_32K = 3'b011;
    localparam block_size_t BA_16K = 3'b001;
    localparam block_size_t BA_8K  = 3'b000;

    typedef enum logic [2:0] {
        READ, UNLOCK1, UNLOCK2, SETUP, SETUP1, SETUP2, AUTOPROG, ID_MODE
    } flash_state_t;

endpackage

`default_nettype wire

// ==== hw/flash_prog_engine.sv ====
`default_nettype none

module flash_prog_engine (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  prog_start,
    input  flash_pkg::word_addr_t prog_addr,
    input  flash_pkg::data_t      prog_data,
    input  logic [1:0]            prog_dsn,
    output logic                  busy,
    mem_if.requester              bus
);
    flash_pkg::data_t new_data;
    logic [1:0]       new_dsn;

    // bus.we tells the read phase from the write phase
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            bus.cs <= 1'b0;
            bus.we <= 1'b0;
        end else if (prog_start) begin
            busy   <= 1'b1;
            bus.cs <= 1'b1;
            bus.we <= 1'b0;
        end else if (busy) begin
            if (bus.cs && bus.ok) begin
                bus.cs <= 1'b0;
                bus.we <= !bus.we;
                busy   <= !bus.we;  // done after the write
            end else if (!bus.cs) begin
                bus.cs <= 1'b1;     // open the write
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_start) begin
            bus.addr <= prog_addr;
            bus.dsn  <= 2'b00;      // read the full word
            new_data <= prog_data;
            new_dsn  <= prog_dsn;
        end else if (bus.cs && bus.ok && !bus.we) begin
            bus.wdata <= bus.rdata & new_data; // bits can only go to zero
            bus.dsn   <= new_dsn;
        end
    end

endmodule

`default_nettype wire

// ==== hw/flash_read_port.sv ====
`default_nettype none

module flash_read_port (
    input  logic                  rst,
    input  logic                  clk,
    input  flash_pkg::dev_type_t  dev_type,
    input  flash_pkg::word_addr_t cpu_addr,
    input  flash_pkg::word_addr_t eff_addr,
    input  logic                  cpu_cs,
    input  logic [1:0]            cpu_we,
    input  logic                  read_mode,
    input  logic                  id_mode,
    input  logic                  busy,
    output flash_pkg::data_t      cpu_din,
    output logic                  cpu_ok,
    mem_if.requester              bus
);
    flash_pkg::data_t id_data;
    logic [7:0]       dev_id;
    logic             rd_done; // one bus read per cpu cycle

    assign bus.we    = 1'b0;
    assign bus.dsn   = 2'b00;
    assign bus.wdata = '0;

    always_comb begin
        case (dev_type)
            flash_pkg::DEV_AB: dev_id = 8'hAB;
            flash_pkg::DEV_2C: dev_id = 8'h2C;
            default:           dev_id = 8'h2F;
        endcase
        case ({cpu_addr[6], cpu_addr[1]})
            2'b00:   id_data = {dev_id, flash_pkg::MFR_ID};
            2'b01:   id_data = 16'h8002;
            default: id_data = '0;  // protection status
        endcase
    end

    assign cpu_din = id_mode ? id_data : bus.rdata;
    assign cpu_ok  = id_mode ? cpu_cs : bus.ok;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bus.cs  <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            if (!cpu_cs)
                rd_done <= 1'b0;
            if (bus.cs) begin
                if (bus.ok) begin
                    bus.cs  <= 1'b0;
                    rd_done <= 1'b1;
                end
            end else if (cpu_cs && cpu_we == 2'b00 && read_mode && !busy && !rd_done) begin
                bus.cs <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!bus.cs)
            bus.addr <= eff_addr; // frozen once the read opens
    end

endmodule

`default_nettype wire

// ==== hw/flash_top.sv ====
`default_nettype none

module flash_top (
    input  logic                  rst,
    input  logic                  clk,
    input  flash_pkg::dev_type_t  dev_type,
    input  flash_pkg::word_addr_t cpu_addr,
    input  logic                  cpu_cs,
    input  logic [1:0]            cpu_we,
    input  flash_pkg::data_t      cpu_dout,
    output flash_pkg::data_t      cpu_din,
    output logic                  rdy,     // low while busy
    output logic                  cpu_ok,
    output flash_pkg::word_addr_t cart_addr,
    output logic                  cart_we,
    output logic                  cart_cs,
    output logic [1:0]            cart_dsn,
    output flash_pkg::data_t      cart_din,
    input  logic                  cart_ok,
    input  flash_pkg::data_t      cart_data
);
    mem_if rd_bus ();
    mem_if prog_bus ();
    mem_if erase_bus ();
    mem_if sd_bus ();

    flash_pkg::word_addr_t  eff_addr;
    flash_pkg::word_addr_t  prog_addr;
    flash_pkg::word_addr_t  erase_base;
    flash_pkg::data_t       prog_data;
    flash_pkg::block_size_t erase_size;
    logic [1:0]             prog_dsn;
    logic                   prog_start;
    logic                   erase_start;
    logic                   prog_busy;
    logic                   erase_busy;
    logic                   id_mode;
    logic                   read_mode;

    assign rdy = ~|{erase_busy, prog_busy, rd_bus.cs};

    assign cart_addr    = sd_bus.addr;
    assign cart_we      = sd_bus.we;
    assign cart_cs      = sd_bus.cs;
    assign cart_dsn     = sd_bus.dsn;
    assign cart_din     = sd_bus.wdata;
    assign sd_bus.ok    = cart_ok;
    assign sd_bus.rdata = cart_data;

    flash_cmd_decoder i_decoder (
        .rst, .clk, .dev_type, .cpu_addr, .cpu_cs, .cpu_we, .cpu_dout,
        .busy        (~rdy),
        .id_mode, .read_mode, .eff_addr,
        .prog_start, .prog_addr, .prog_data, .prog_dsn,
        .erase_start, .erase_base, .erase_size
    );

    flash_read_port i_read_port (
        .rst, .clk, .dev_type, .cpu_addr, .eff_addr, .cpu_cs, .cpu_we,
        .read_mode, .id_mode,
        .busy    (prog_busy | erase_busy),
        .cpu_din, .cpu_ok,
        .bus     (rd_bus)
    );

    flash_prog_engine i_prog (
        .rst, .clk, .prog_start, .prog_addr, .prog_data, .prog_dsn,
        .busy (prog_busy),
        .bus  (prog_bus)
    );

    flash_erase_engine i_erase (
        .rst, .clk, .erase_start, .erase_base, .erase_size,
        .busy (erase_busy),
        .bus  (erase_bus)
    );

    mem_arbiter i_arbiter (
        .rst, .clk,
        .erase_bus (erase_bus),
        .prog_bus  (prog_bus),
        .rd_bus    (rd_bus),
        .sd_bus    (sd_bus)
    );

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
    input  logic     rst,
    input  logic     clk,
    mem_if.server    erase_bus,
    mem_if.server    prog_bus,
    mem_if.server    rd_bus,
    mem_if.requester sd_bus
);
    logic [2:0] gnt; // one hot {erase, prog, read}

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            gnt <= 3'b000;
        end else if (gnt == 3'b000) begin
            if (!sd_bus.ok) begin   // last transaction fully closed
                if (erase_bus.cs)
                    gnt <= 3'b100;
                else if (prog_bus.cs)
                    gnt <= 3'b010;
                else if (rd_bus.cs)
                    gnt <= 3'b001;
            end
        end else if (sd_bus.ok) begin
            gnt <= 3'b000;
        end
    end

    always_comb begin
        sd_bus.addr  = rd_bus.addr;
        sd_bus.we    = rd_bus.we;
        sd_bus.dsn   = rd_bus.dsn;
        sd_bus.wdata = rd_bus.wdata;
        sd_bus.cs    = gnt[0] & rd_bus.cs;
        if (gnt[1]) begin
            sd_bus.addr  = prog_bus.addr;
            sd_bus.we    = prog_bus.we;
            sd_bus.dsn   = prog_bus.dsn;
            sd_bus.wdata = prog_bus.wdata;
            sd_bus.cs    = prog_bus.cs;
        end
        if (gnt[2]) begin
            sd_bus.addr  = erase_bus.addr;
            sd_bus.we    = erase_bus.we;
            sd_bus.dsn   = erase_bus.dsn;
            sd_bus.wdata = erase_bus.wdata;
            sd_bus.cs    = erase_bus.cs;
        end
    end

    assign erase_bus.ok    = gnt[2] & sd_bus.ok;
    assign prog_bus.ok     = gnt[1] & sd_bus.ok;
    assign rd_bus.ok       = gnt[0] & sd_bus.ok;
    assign erase_bus.rdata = gnt[2] ? sd_bus.rdata : '0;
    assign prog_bus.rdata  = gnt[1] ? sd_bus.rdata : '0;
    assign rd_bus.rdata    = gnt[0] ? sd_bus.rdata : '0;

endmodule

`default_nettype wire

// ==== hw/mem_if.sv ====
`default_nettype none

// one word port toward the sdram
interface mem_if;
    flash_pkg::word_addr_t addr;
    logic                  cs;
    logic                  we;
    logic [1:0]            dsn;   // active low byte enables
    flash_pkg::data_t      wdata;
    flash_pkg::data_t      rdata; // valid while ok is high
    logic                  ok;

    modport requester (
        output addr, cs, we, dsn, wdata,
        input  rdata, ok
    );

    modport server (
        input  addr, cs, we, dsn, wdata,
        output rdata, ok
    );
endinterface

`default_nettype wire

// ==== testbench/flash_assert.sv ====
`default_nettype none

// sdram port protocol and ready output
module flash_assert_checks (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs,
    input  logic       ok,
    input  logic [2:0] gnt,
    input  logic [2:0] req,   // cs of {erase, prog, read}
    input  logic [1:0] start,
    input  logic       rdy
);
    timeunit 1ns;
    timeprecision 1ps;

    // a transaction closes only after ok
    cs_held: assert property (@(posedge clk) disable iff (rst) $fell(cs) |-> $past(ok))
        else $error("cart_cs dropped while the transaction was still open");

    // grant stays with the engine that still requests
    one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(gnt) && (gnt & ~req) == 3'b000)
        else $error("the sdram grant is held by more than one engine or by an idle one");

    busy_rdy: assert property (@(posedge clk) disable iff (rst) (|start) |=> !rdy)
        else $error("rdy stayed high after an engine was started");

endmodule

bind flash_top flash_assert_checks i_checks (
    .clk,
    .rst,
    .cs    (cart_cs),
    .ok    (cart_ok),
    .gnt   (i_arbiter.gnt),
    .req   ({erase_bus.cs, prog_bus.cs, rd_bus.cs}),
    .start ({erase_start, prog_start}),
    .rdy
);

`default_nettype wire

// ==== testbench/flash_tb.sv ====
`default_nettype none

module flash_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk = 1'b0;
    logic                  rst;
    flash_pkg::dev_type_t  dev_type;
    flash_pkg::word_addr_t cpu_addr;
    logic                  cpu_cs;
    logic [1:0]            cpu_we;
    flash_pkg::data_t      cpu_dout;
    flash_pkg::data_t      cpu_din;
    logic                  rdy;
    logic                  cpu_ok;
    flash_pkg::word_addr_t cart_addr;
    logic                  cart_we;
    logic                  cart_cs;
    logic [1:0]            cart_dsn;
    flash_pkg::data_t      cart_din;
    logic                  cart_ok = 1'b0;
    flash_pkg::data_t      cart_data = '0;

    flash_pkg::data_t sd_mem  [0:1048575]; // contents the dut left in sdram
    flash_pkg::data_t ref_mem [0:1048575]; // expected flash contents
    flash_pkg::word_addr_t at_5555 = {5'd0, flash_pkg::ADDR_5555};
    flash_pkg::word_addr_t at_2aaa = {5'd0, flash_pkg::ADDR_2AAA};
    logic [31:0] lcg_state = 32'd72664;
    logic        sd_open = 1'b0;
    logic [1:0]  sd_wait = 2'd0;
    int          errors = 0;
    int          timeouts = 0;

    always #2 clk = ~clk;

    flash_top i_flash_top (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic flash_pkg::word_addr_t rand_addr();
        logic [31:0] r;
        r = next_random();
        return r[31:12];
    endfunction

    // initial array contents, every address bit takes part
    function automatic flash_pkg::data_t fill_word(input flash_pkg::word_addr_t a,
                                                   input flash_pkg::data_t key);
        return key ^ (a[16:1] * 16'd40503) ^ {a[20:17], a[12:1]};
    endfunction

    function automatic flash_pkg::word_addr_t dev_mask(input flash_pkg::word_addr_t a);
        if (dev_type == flash_pkg::DEV_AB)
            a[20:19] = 2'b00;
        else if (dev_type == flash_pkg::DEV_2C)
            a[20] = 1'b0;
        return a;
    endfunction

    function automatic flash_pkg::data_t id_word(input flash_pkg::word_addr_t a);
        logic [7:0] code;
        case (dev_type)
            flash_pkg::DEV_AB: code = 8'hAB;
            flash_pkg::DEV_2C: code = 8'h2C;
            default:           code = 8'h2F;
        endcase
        if (a[6])
            return 16'h0000;
        else if (a[1])
            return 16'h8002;
        return {code, 8'h98};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // sdram model, ok after 1 to 4 cycles
    always @(posedge clk, posedge rst) begin : sdram_model
        logic [31:0] r;
        if (rst) begin
            cart_ok <= 1'b0;
            sd_open <= 1'b0;
            sd_wait <= 2'd0;
        end else if (cart_ok) begin
            cart_ok <= 1'b0;
        end else if (cart_cs) begin
            if (!sd_open) begin
                r = next_random();
                sd_open <= 1'b1;
                sd_wait <= r[31:30];
            end else if (sd_wait != 2'd0) begin
                sd_wait <= sd_wait - 2'd1;
            end else begin
                sd_open   <= 1'b0;
                cart_ok   <= 1'b1;
                cart_data <= sd_mem[cart_addr];
                if (cart_we && !cart_dsn[0])
                    sd_mem[cart_addr][7:0] = cart_din[7:0];
                if (cart_we && !cart_dsn[1])
                    sd_mem[cart_addr][15:8] = cart_din[15:8];
            end
        end
    end

    task automatic wait_rdy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (rdy !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rdy !== level) begin
            timeouts++;
            $display("timeout at %0t ns: rdy never went to %0d during %s", $time, level, what);
        end
    endtask

    task automatic cpu_write(input flash_pkg::word_addr_t a, input flash_pkg::data_t d,
                             input logic [1:0] we);
        wait_rdy(1'b1, 100, "a cpu write");
        @(posedge clk);
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_we   <= we;
        cpu_cs   <= 1'b1;
        @(posedge clk);
        cpu_cs <= 1'b0;
        cpu_we <= 2'b00;
        @(posedge clk);
    endtask

    task automatic cpu_read(input flash_pkg::word_addr_t a, output flash_pkg::data_t d);
        int n;
        @(posedge clk);
        cpu_addr <= a;
        cpu_we   <= 2'b00;
        cpu_cs   <= 1'b1;
        n = 0;
        @(negedge clk);
        while (cpu_ok !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (cpu_ok !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t ns: no cpu_ok for the read of %h", $time, a);
        end
        d = cpu_din;
        @(posedge clk);
        cpu_cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic read_check(input flash_pkg::word_addr_t a, input string what);
        flash_pkg::data_t got;
        cpu_read(a, got);
        check(got, ref_mem[dev_mask(a)], what);
    endtask

    task automatic unlock(input logic [7:0] cmd);
        cpu_write(at_5555, 16'h00AA, 2'b11);
        cpu_write(at_2aaa, 16'h0055, 2'b11);
        cpu_write(at_5555, {8'h00, cmd}, 2'b11);
    endtask

    task automatic program_word(input flash_pkg::word_addr_t a, input flash_pkg::data_t d,
                                input logic [1:0] we);
        flash_pkg::word_addr_t e;
        flash_pkg::data_t      old;
        e = dev_mask(a);
        old = ref_mem[e];
        unlock(8'hA0);
        cpu_write(a, d, we);
        wait_rdy(1'b0, 20, "program start");
        wait_rdy(1'b1, 100, "program end");
        if (we[0])
            ref_mem[e][7:0] = old[7:0] & d[7:0];   // bits only clear
        if (we[1])
            ref_mem[e][15:8] = old[15:8] & d[15:8];
        check(sd_mem[e], ref_mem[e], "programmed word in sdram");
        read_check(a, "read after program");
    endtask

    task automatic erase_block(input flash_pkg::word_addr_t a);
        flash_pkg::word_addr_t e;
        flash_pkg::word_addr_t lo;
        flash_pkg::word_addr_t below;
        flash_pkg::word_addr_t above;
        logic                  top;
        int                    n;
        e = dev_mask(a);
        case (dev_type)
            flash_pkg::DEV_AB: top = &e[18:16];
            flash_pkg::DEV_2C: top = &e[19:16];
            default:           top = &e[20:16];
        endcase
        lo = e;
        lo[15:1] = '0;
        n = 32768;
        // top 64 kB splits into 32K, 8K, 8K, 16K
        if (top && !e[15]) begin
            n = 16384;
        end else if (top && !e[14]) begin
            lo[15:13] = {2'b10, e[13]};
            n = 4096;
        end else if (top) begin
            lo[15:14] = 2'b11;
            n = 8192;
        end
        unlock(8'h80);
        cpu_write(at_5555, 16'h00AA, 2'b11);
        cpu_write(at_2aaa, 16'h0055, 2'b11);
        cpu_write(a, 16'h0030, 2'b11);
        wait_rdy(1'b0, 20, "erase start");
        wait_rdy(1'b1, n * 10 + 100, "erase end");
        for (int i = 0; i < n; i++) begin
            ref_mem[lo + i] = 16'hFFFF;
            check(sd_mem[lo + i], 16'hFFFF, "erased word");
        end
        below = lo - 20'd1;
        above = lo + n[19:0];
        check(sd_mem[below], ref_mem[below], "word below erased block");
        check(sd_mem[above], ref_mem[above], "word above erased block");
        read_check(a, "read inside erased block");
    endtask

    task automatic id_checks();
        flash_pkg::word_addr_t a;
        flash_pkg::data_t      got;
        for (int k = 0; k < 3; k++) begin
            a = rand_addr();
            a[1] = k[0]; // id byte, then 8002
            a[6] = k[1]; // protection status word
            unlock(8'h90);
            cpu_read(a, got);
            check(got, id_word(a), "id word");
            repeat (2) @(posedge clk);
            read_check(rand_addr(), "read after id mode");
        end
    endtask

    task automatic broken_sequences();
        flash_pkg::word_addr_t a;
        a = rand_addr();
        cpu_write(at_5555, 16'h00AA, 2'b11);
        cpu_write(at_5555, 16'h0055, 2'b11); // 55 at the wrong address
        cpu_write(a, 16'h0000, 2'b11);
        unlock(8'hF0);
        cpu_write(a, 16'h0000, 2'b11);
        unlock(8'h80);
        cpu_write(at_5555, 16'h00AA, 2'b11);
        cpu_write(at_2aaa, 16'h0055, 2'b11);
        cpu_write(a, 16'h0010, 2'b11);       // not an erase byte
        repeat (4) @(posedge clk);
        @(negedge clk);
        check(rdy, 1, "rdy after broken sequences");
        check(sd_mem[dev_mask(a)], ref_mem[dev_mask(a)], "word after broken sequences");
        read_check(a, "read after broken sequences");
    endtask

    initial begin
        flash_pkg::word_addr_t a;
        flash_pkg::data_t      key;
        flash_pkg::data_t      w;
        logic [31:0]           r;
        rst      = 1'b1;
        dev_type = flash_pkg::DEV_2F;
        cpu_addr = '0;
        cpu_cs   = 1'b0;
        cpu_we   = 2'b00;
        cpu_dout = '0;
        r = next_random();
        key = r[31:16];
        for (int i = 0; i < 1048576; i++) begin
            w = fill_word(i[19:0], key);
            sd_mem[i]  = w;
            ref_mem[i] = w;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check(rdy, 1, "rdy after reset");
        check(cpu_ok, 0, "cpu_ok after reset");
        check(cart_cs, 0, "cart_cs after reset");
        check(cart_we, 0, "cart_we after reset");

        for (int p = 0; p < 3; p++) begin
            @(posedge clk);
            case (p)
                0:       dev_type <= flash_pkg::DEV_2F;
                1:       dev_type <= flash_pkg::DEV_2C;
                default: dev_type <= flash_pkg::DEV_AB;
            endcase
            repeat (2) @(posedge clk);
            for (int k = 0; k < 6; k++)
                read_check(rand_addr(), "random read");
            for (int k = 0; k < 4; k++) begin
                r = next_random();
                program_word(rand_addr(), r[15:0], r[31:30] == 2'b00 ? 2'b11 : r[31:30]);
            end
            id_checks();
            broken_sequences();
            if (p == 0) begin
                a = rand_addr();
                a[20] = 1'b0;            // plain 64 kB block
                erase_block(a);
                a = rand_addr();
                a[20:15] = 6'b111110;    // 32K boot block
                erase_block(a);
                a = rand_addr();
                a[20:13] = 8'hFC;        // first 8K
                erase_block(a);
                a = rand_addr();
                a[20:13] = 8'hFD;        // second 8K
                erase_block(a);
                a = rand_addr();
                a[20:14] = 7'h7F;        // 16K
                erase_block(a);
            end else if (p == 1) begin
                a = rand_addr();
                a[19:14] = 6'h3F;
                erase_block(a);
            end else begin
                a = rand_addr();
                a[18:13] = 6'b111101;    // bits 20:19 get masked away
                erase_block(a);
            end
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
